/* hdl/core_pkg.sv */
package core_pkg;

	// datapath and register index widths
	localparam int xlen = 32;
	localparam int reg_addr_w = 5;

	typedef logic [xlen-1:0] word_t;
	typedef logic [reg_addr_w-1:0] reg_addr_t;

	// first fetch address after reset
	localparam word_t reset_pc = 32'h0000_0000;

	// addi x0, x0, 0
	localparam word_t nop_instr = 32'h0000_0013;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		op_rtype  = 7'b0110011,
		op_imm    = 7'b0010011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_branch = 7'b1100011,
		op_jal    = 7'b1101111
	} opcode_e;

	// funct3 codes for r-type and addi
	localparam logic [2:0] f3_add_sub = 3'b000;
	localparam logic [2:0] f3_slt     = 3'b010;
	localparam logic [2:0] f3_xor     = 3'b100;
	localparam logic [2:0] f3_or      = 3'b110;
	localparam logic [2:0] f3_and     = 3'b111;

	// funct7 that turns add into sub
	localparam logic [6:0] f7_sub = 7'b0100000;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt
	} alu_op_e;

endpackage

/* hdl/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage import core_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  word_t     if_pc,
	input  word_t     if_instr,
	input  logic      branch_taken,
	input  reg_addr_t wb_rd,
	input  logic      wb_reg_write,
	input  word_t     wb_data,
	output logic      stall,
	output logic      jump,
	output word_t     jump_target,
	output word_t     id_pc,
	output word_t     id_rs1_data,
	output word_t     id_rs2_data,
	output reg_addr_t id_rs1,
	output reg_addr_t id_rs2,
	output reg_addr_t id_rd,
	output word_t     id_imm,
	output alu_op_e   id_alu_op,
	output logic      id_use_imm,
	output logic      id_mem_read,
	output logic      id_mem_write,
	output logic      id_reg_write,
	output logic      id_is_branch
);

	word_t regs [0:31];

	opcode_e opcode;
	word_t imm_i, imm_s, imm_b, imm_j;
	word_t imm, rs1_data, rs2_data;
	reg_addr_t rs1, rs2, rd;
	alu_op_e alu_op;
	logic use_rs1, use_rs2, use_imm;
	logic mem_read, mem_write, reg_write, is_branch, is_jal;
	logic bubble;

	assign opcode = opcode_e'(if_instr[6:0]);

	assign imm_i = {{20{if_instr[31]}}, if_instr[31:20]};
	assign imm_s = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
	assign imm_b = {{19{if_instr[31]}}, if_instr[31], if_instr[7],
		if_instr[30:25], if_instr[11:8], 1'b0};
	assign imm_j = {{11{if_instr[31]}}, if_instr[31], if_instr[19:12],
		if_instr[20], if_instr[30:21], 1'b0};

	always_comb begin
		imm       = '0;
		alu_op    = alu_add;
		use_rs1   = 1'b0;
		use_rs2   = 1'b0;
		use_imm   = 1'b0;
		mem_read  = 1'b0;
		mem_write = 1'b0;
		reg_write = 1'b0;
		is_branch = 1'b0;
		is_jal    = 1'b0;
		case (opcode)
			op_rtype: begin
				use_rs1   = 1'b1;
				use_rs2   = 1'b1;
				reg_write = 1'b1;
				case (if_instr[14:12])
					f3_add_sub: alu_op = (if_instr[31:25] == f7_sub) ? alu_sub : alu_add;
					f3_slt: alu_op = alu_slt;
					f3_xor: alu_op = alu_xor;
					f3_or: alu_op = alu_or;
					f3_and: alu_op = alu_and;
					default: reg_write = 1'b0;
				endcase
			end
			op_imm: begin
				// addi only
				use_rs1   = 1'b1;
				use_imm   = 1'b1;
				imm       = imm_i;
				reg_write = (if_instr[14:12] == f3_add_sub);
			end
			op_load: begin
				use_rs1   = 1'b1;
				use_imm   = 1'b1;
				imm       = imm_i;
				mem_read  = 1'b1;
				reg_write = 1'b1;
			end
			op_store: begin
				use_rs1   = 1'b1;
				use_rs2   = 1'b1;
				use_imm   = 1'b1;
				imm       = imm_s;
				mem_write = 1'b1;
			end
			op_branch: begin
				use_rs1   = 1'b1;
				use_rs2   = 1'b1;
				imm       = imm_b;
				is_branch = 1'b1;
			end
			op_jal: begin
				// link value rides down as x0 + (pc + 4)
				is_jal    = 1'b1;
				use_imm   = 1'b1;
				imm       = if_pc + word_t'(4);
				reg_write = 1'b1;
			end
			default: begin
			end
		endcase
	end

	// unused fields collapse to x0 so they never match a hazard
	assign rs1 = use_rs1 ? if_instr[19:15] : '0;
	assign rs2 = use_rs2 ? if_instr[24:20] : '0;
	assign rd  = reg_write ? if_instr[11:7] : '0;

	// register file with write-through to the read ports
	always_ff @(posedge clock) begin
		if (wb_reg_write && wb_rd != '0) begin
			regs[wb_rd] <= wb_data;
		end
	end

	assign rs1_data = (rs1 == '0) ? '0 :
		(wb_reg_write && wb_rd == rs1) ? wb_data : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 :
		(wb_reg_write && wb_rd == rs2) ? wb_data : regs[rs2];

	// load in execute feeding the instruction in decode
	assign stall = id_mem_read && id_rd != '0 &&
		((use_rs1 && rs1 == id_rd) || (use_rs2 && rs2 == id_rd));

	assign jump        = is_jal;
	assign jump_target = if_pc + imm_j;
	assign bubble      = stall || branch_taken;

	// ID/EX control
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			id_rs1       <= '0;
			id_rs2       <= '0;
			id_rd        <= '0;
			id_mem_read  <= 1'b0;
			id_mem_write <= 1'b0;
			id_reg_write <= 1'b0;
			id_is_branch <= 1'b0;
		end else if (bubble) begin
			id_rs1       <= '0;
			id_rs2       <= '0;
			id_rd        <= '0;
			id_mem_read  <= 1'b0;
			id_mem_write <= 1'b0;
			id_reg_write <= 1'b0;
			id_is_branch <= 1'b0;
		end else begin
			id_rs1       <= rs1;
			id_rs2       <= rs2;
			id_rd        <= rd;
			id_mem_read  <= mem_read;
			id_mem_write <= mem_write;
			id_reg_write <= reg_write;
			id_is_branch <= is_branch;
		end
	end

	// ID/EX payload
	always_ff @(posedge clock) begin
		id_pc       <= if_pc;
		id_rs1_data <= rs1_data;
		id_rs2_data <= rs2_data;
		id_imm      <= imm;
		id_alu_op   <= alu_op;
		id_use_imm  <= use_imm;
	end

endmodule

/* hdl/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage import core_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  word_t     id_pc,
	input  word_t     id_rs1_data,
	input  word_t     id_rs2_data,
	input  reg_addr_t id_rs1,
	input  reg_addr_t id_rs2,
	input  reg_addr_t id_rd,
	input  word_t     id_imm,
	input  alu_op_e   id_alu_op,
	input  logic      id_use_imm,
	input  logic      id_mem_read,
	input  logic      id_mem_write,
	input  logic      id_reg_write,
	input  logic      id_is_branch,
	input  reg_addr_t wb_rd,
	input  logic      wb_reg_write,
	input  word_t     wb_data,
	output logic      branch_taken,
	output word_t     branch_target,
	output word_t     ex_alu_result,
	output word_t     ex_store_data,
	output reg_addr_t ex_rd,
	output logic      ex_mem_read,
	output logic      ex_mem_write,
	output logic      ex_reg_write
);

	word_t fwd_a, fwd_b;
	word_t alu_b, alu_result;
	logic less_than;

	// youngest producer first, then writeback, then the decode read
	assign fwd_a = (ex_reg_write && ex_rd != '0 && ex_rd == id_rs1) ? ex_alu_result :
		(wb_reg_write && wb_rd != '0 && wb_rd == id_rs1) ? wb_data : id_rs1_data;
	assign fwd_b = (ex_reg_write && ex_rd != '0 && ex_rd == id_rs2) ? ex_alu_result :
		(wb_reg_write && wb_rd != '0 && wb_rd == id_rs2) ? wb_data : id_rs2_data;

	assign alu_b     = id_use_imm ? id_imm : fwd_b;
	assign less_than = $signed(fwd_a) < $signed(alu_b);

	always_comb begin
		case (id_alu_op)
			alu_add: alu_result = fwd_a + alu_b;
			alu_sub: alu_result = fwd_a - alu_b;
			alu_and: alu_result = fwd_a & alu_b;
			alu_or: alu_result = fwd_a | alu_b;
			alu_xor: alu_result = fwd_a ^ alu_b;
			alu_slt: alu_result = {{(xlen-1){1'b0}}, less_than};
			default: alu_result = fwd_a + alu_b;
		endcase
	end

	// beq resolves here
	assign branch_taken  = id_is_branch && (fwd_a == fwd_b);
	assign branch_target = id_pc + id_imm;

	// EX/MEM control
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			ex_rd        <= '0;
			ex_mem_read  <= 1'b0;
			ex_mem_write <= 1'b0;
			ex_reg_write <= 1'b0;
		end else begin
			ex_rd        <= id_rd;
			ex_mem_read  <= id_mem_read;
			ex_mem_write <= id_mem_write;
			ex_reg_write <= id_reg_write;
		end
	end

	// EX/MEM payload
	always_ff @(posedge clock) begin
		ex_alu_result <= alu_result;
		ex_store_data <= fwd_b;
	end

endmodule

/* hdl/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage import core_pkg::*; (
	input  logic  clock,
	input  logic  reset,
	input  logic  stall,
	input  logic  jump,
	input  word_t jump_target,
	input  logic  branch_taken,
	input  word_t branch_target,
	input  word_t instr,
	output word_t pc,
	output word_t if_pc,
	output word_t if_instr
);

	word_t next_pc;

	// a branch in execute is older than a jump in decode, so it wins
	always_comb begin
		if (branch_taken) begin
			next_pc = branch_target;
		end else if (jump) begin
			next_pc = jump_target;
		end else if (stall) begin
			next_pc = pc;
		end else begin
			next_pc = pc + word_t'(4);
		end
	end

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			pc <= reset_pc;
		end else begin
			pc <= next_pc;
		end
	end

	// IF/ID register
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			if_pc    <= reset_pc;
			if_instr <= nop_instr;
		end else if (branch_taken || jump) begin
			// squash the wrong-path fetch
			if_pc    <= pc;
			if_instr <= nop_instr;
		end else if (!stall) begin
			if_pc    <= pc;
			if_instr <= instr;
		end
	end

endmodule

/* hdl/mem_writeback.sv */
`timescale 1ns/1ps

module mem_writeback import core_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  word_t     ex_alu_result,
	input  word_t     ex_store_data,
	input  reg_addr_t ex_rd,
	input  logic      ex_mem_read,
	input  logic      ex_mem_write,
	input  logic      ex_reg_write,
	input  word_t     data_in,
	output word_t     data_addr,
	output logic      ren,
	output logic      wen,
	output word_t     data_out,
	output reg_addr_t wb_rd,
	output logic      wb_reg_write,
	output word_t     wb_data
);

	logic wb_from_mem;
	word_t wb_load_data, wb_alu_result;

	// data memory answers in the same cycle
	assign data_addr = ex_alu_result;
	assign ren       = ex_mem_read;
	assign wen       = ex_mem_write;
	assign data_out  = ex_store_data;

	// MEM/WB control
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			wb_rd        <= '0;
			wb_reg_write <= 1'b0;
			wb_from_mem  <= 1'b0;
		end else begin
			wb_rd        <= ex_rd;
			wb_reg_write <= ex_reg_write;
			wb_from_mem  <= ex_mem_read;
		end
	end

	// MEM/WB payload
	always_ff @(posedge clock) begin
		wb_load_data  <= data_in;
		wb_alu_result <= ex_alu_result;
	end

	// feeds the register file and the execute bypass
	assign wb_data = wb_from_mem ? wb_load_data : wb_alu_result;

endmodule

/* hdl/pipeline_core.sv */
`timescale 1ns/1ps

module pipeline_core import core_pkg::*; (
	input  logic  clock,
	input  logic  reset,
	output word_t pc,
	input  word_t instr,
	output word_t data_addr,
	output logic  ren,
	output logic  wen,
	output word_t data_out,
	input  word_t data_in
);

	// fetch to decode
	word_t if_pc, if_instr;

	// redirects and stall
	logic stall, jump, branch_taken;
	word_t jump_target, branch_target;

	// ID/EX
	word_t id_pc, id_rs1_data, id_rs2_data, id_imm;
	reg_addr_t id_rs1, id_rs2, id_rd;
	alu_op_e id_alu_op;
	logic id_use_imm, id_mem_read, id_mem_write, id_reg_write, id_is_branch;

	// EX/MEM
	word_t ex_alu_result, ex_store_data;
	reg_addr_t ex_rd;
	logic ex_mem_read, ex_mem_write, ex_reg_write;

	// MEM/WB
	reg_addr_t wb_rd;
	logic wb_reg_write;
	word_t wb_data;

	// port names match the wires above one to one
	fetch_stage fetch_stage_i (
		.*
	);

	decode_stage decode_stage_i (
		.*
	);

	execute_stage execute_stage_i (
		.*
	);

	mem_writeback mem_writeback_i (
		.*
	);

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module core_tb -f sources.f -o core_sim

status=0
./obj_dir/core_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "sim passed" sim.log; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi

/* sim/core_assert.sv */
`timescale 1ns/1ps

module core_assert import core_pkg::*; (
	input logic  clock,
	input logic  reset,
	input word_t pc,
	input logic  ren,
	input logic  wen,
	input logic  stall,
	input logic  jump,
	input logic  branch_taken
);

	// one access per cycle on the data port
	rw_exclusive: assert property (@(posedge clock) disable iff (!reset) !(ren && wen))
		else $error("ren and wen high in the same cycle");

	// pipeline is empty for the first three cycles after reset
	wen_low_after_reset: assert property (@(posedge clock)
		(reset && (!$past(reset) || !$past(reset, 2) || !$past(reset, 3))) |-> !wen)
		else $error("wen high while the pipeline should still be empty");

	// sequential fetch when nothing redirects or holds
	pc_step: assert property (@(posedge clock) disable iff (!reset)
		($past(reset) && !$past(stall) && !$past(jump) && !$past(branch_taken))
		|-> pc == $past(pc) + word_t'(4))
		else $error("pc did not advance by 4");

endmodule

bind pipeline_core core_assert core_assert_i (
	.clock(clock),
	.reset(reset),
	.pc(pc),
	.ren(ren),
	.wen(wen),
	.stall(stall),
	.jump(jump),
	.branch_taken(branch_taken)
);

/* sim/core_tb.sv */
`timescale 1ns/1ps

module core_tb import core_pkg::*; ();

	localparam int imem_depth = 256;
	localparam int dmem_depth = 256;
	localparam word_t end_addr = 32'h0000_03f0;
	// five short programs plus reset stay well below this
	localparam int max_cycles = 2000;

	logic clock;
	logic reset;
	word_t pc;
	word_t instr = nop_instr;
	word_t data_addr;
	logic ren;
	logic wen;
	word_t data_out;
	word_t data_in = '0;

	word_t imem [0:imem_depth-1];
	word_t dmem [0:dmem_depth-1];
	word_t store_addr_q[$];
	word_t store_data_q[$];
	word_t exp_addr_q[$];
	word_t exp_data_q[$];
	logic end_seen;
	int slot;
	int cycle_count = 0;

	pipeline_core pipeline_core_i (.*);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= max_cycles) begin
			$display("cycle limit of %0d reached before the program finished", max_cycles);
			$display("sim failed");
			$fatal(1, "timeout");
		end
	end

	// memories answer mid-cycle from stable addresses
	always @(negedge clock) begin
		if (!reset) begin
			end_seen = 1'b0;
			store_addr_q.delete();
			store_data_q.delete();
		end else if (wen) begin
			if (data_addr == end_addr) begin
				end_seen = 1'b1;
			end else begin
				dmem[data_addr[9:2]] = data_out;
				store_addr_q.push_back(data_addr);
				store_data_q.push_back(data_out);
			end
		end
		instr = imem[pc[9:2]];
		// read data only while ren is high
		data_in = ren ? dmem[data_addr[9:2]] : '0;
	end

	function automatic word_t fill_word(word_t addr);
		return 32'hd47a_0000 ^ addr;
	endfunction

	function automatic word_t r_type(logic [2:0] f3, logic [6:0] f7, int rd, int rs1, int rs2);
		return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), op_rtype};
	endfunction

	function automatic word_t addi(int rd, int rs1, int imm);
		return {12'(imm), 5'(rs1), f3_add_sub, 5'(rd), op_imm};
	endfunction

	function automatic word_t lw(int rd, int rs1, int imm);
		return {12'(imm), 5'(rs1), 3'b010, 5'(rd), op_load};
	endfunction

	function automatic word_t sw(int src, int base, int imm);
		logic [11:0] s;
		s = 12'(imm);
		return {s[11:5], 5'(src), 5'(base), 3'b010, s[4:0], op_store};
	endfunction

	function automatic word_t beq(int rs1, int rs2, int offset);
		logic [12:0] o;
		o = 13'(offset);
		return {o[12], o[10:5], 5'(rs2), 5'(rs1), 3'b000, o[4:1], o[11], op_branch};
	endfunction

	function automatic word_t jal(int rd, int offset);
		logic [20:0] o;
		o = 21'(offset);
		return {o[20], o[10:1], o[11], o[19:12], 5'(rd), op_jal};
	endfunction

	task automatic check_value(input string test_name, input string what,
		input word_t expected, input word_t actual);
		if (expected !== actual) begin
			$display("** Error %s (%s): expected %h, actual %h", test_name, what, expected, actual);
			$display("sim failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// hold reset and load fresh memories
	task automatic start_test();
		@(negedge clock);
		reset = 1'b0;
		slot = 0;
		exp_addr_q.delete();
		exp_data_q.delete();
		for (int i = 0; i < imem_depth; i++) begin
			imem[i[7:0]] = nop_instr;
		end
		for (int i = 0; i < dmem_depth; i++) begin
			dmem[i[7:0]] = fill_word(word_t'(i * 4));
		end
	endtask

	task automatic release_reset();
		repeat (4) @(negedge clock);
		reset = 1'b1;
	endtask

	task automatic emit(input word_t w);
		imem[slot[7:0]] = w;
		slot++;
	endtask

	task automatic emit_end();
		emit(sw(0, 0, int'(end_addr)));
	endtask

	task automatic expect_store(input word_t addr, input word_t data);
		exp_addr_q.push_back(addr);
		exp_data_q.push_back(data);
	endtask

	task automatic wait_for_end();
		while (!end_seen) @(posedge clock);
	endtask

	task automatic compare_stores(input string test_name);
		check_value(test_name, "store count", word_t'(exp_addr_q.size()),
			word_t'(store_addr_q.size()));
		for (int i = 0; i < exp_addr_q.size(); i++) begin
			check_value(test_name, "store address", exp_addr_q[i], store_addr_q[i]);
			check_value(test_name, "store data", exp_data_q[i], store_data_q[i]);
		end
	endtask

	// each result of the chain needs the one before it
	task automatic arith_forwarding();
		word_t a, b, r_add, r_sub, r_and, r_or, r_xor, r_addi;
		a = word_t'(25);
		b = word_t'(-7);
		r_add = a + b;
		r_sub = r_add - a;
		r_and = r_sub & r_add;
		r_or = r_and | a;
		r_xor = r_or ^ r_sub;
		r_addi = r_xor + word_t'(100);
		start_test();
		emit(addi(1, 0, 25));
		emit(addi(2, 0, -7));
		emit(r_type(f3_add_sub, 7'b0, 3, 1, 2));
		emit(r_type(f3_add_sub, f7_sub, 4, 3, 1));
		emit(r_type(f3_and, 7'b0, 5, 4, 3));
		emit(r_type(f3_or, 7'b0, 6, 5, 1));
		emit(r_type(f3_xor, 7'b0, 7, 6, 4));
		emit(addi(8, 7, 100));
		emit(sw(8, 0, 'h100));
		emit(sw(3, 0, 'h104));
		emit(sw(4, 0, 'h108));
		emit(sw(5, 0, 'h10c));
		emit(sw(6, 0, 'h110));
		emit(sw(7, 0, 'h114));
		emit_end();
		expect_store(32'h100, r_addi);
		expect_store(32'h104, r_add);
		expect_store(32'h108, r_sub);
		expect_store(32'h10c, r_and);
		expect_store(32'h110, r_or);
		expect_store(32'h114, r_xor);
		release_reset();
		wait_for_end();
		compare_stores("arith_forward");
	endtask

	task automatic slt_and_x0();
		word_t m1, p1;
		m1 = word_t'(-1);
		p1 = word_t'(1);
		start_test();
		emit(addi(1, 0, -1));
		emit(addi(2, 0, 1));
		emit(r_type(f3_slt, 7'b0, 3, 1, 2));
		emit(r_type(f3_slt, 7'b0, 4, 2, 1));
		emit(r_type(f3_slt, 7'b0, 5, 1, 1));
		emit(addi(0, 0, 55));
		emit(r_type(f3_add_sub, 7'b0, 6, 0, 2));
		emit(sw(3, 0, 'h110));
		emit(sw(4, 0, 'h114));
		emit(sw(5, 0, 'h118));
		emit(sw(6, 0, 'h11c));
		emit(sw(0, 0, 'h120));
		emit_end();
		expect_store(32'h110, ($signed(m1) < $signed(p1)) ? 32'd1 : 32'd0);
		expect_store(32'h114, ($signed(p1) < $signed(m1)) ? 32'd1 : 32'd0);
		expect_store(32'h118, ($signed(m1) < $signed(m1)) ? 32'd1 : 32'd0);
		expect_store(32'h11c, p1);
		expect_store(32'h120, 32'd0);
		release_reset();
		wait_for_end();
		compare_stores("slt_x0");
	endtask

	task automatic load_use_stall();
		word_t pre;
		pre = 32'h1234_5678;
		start_test();
		dmem[8'h80] = pre;
		emit(addi(1, 0, 'h200));
		emit(addi(2, 0, 'h333));
		emit(lw(3, 1, 0));
		emit(r_type(f3_add_sub, 7'b0, 4, 3, 2));
		emit(sw(4, 0, 'h130));
		emit(lw(5, 1, 4));
		emit(sw(5, 0, 'h134));
		emit(lw(6, 1, 0));
		emit(addi(7, 0, 1));
		emit(r_type(f3_add_sub, 7'b0, 8, 6, 7));
		emit(sw(8, 0, 'h138));
		emit_end();
		expect_store(32'h130, pre + 32'h333);
		expect_store(32'h134, fill_word(32'h204));
		expect_store(32'h138, pre + 32'd1);
		release_reset();
		wait_for_end();
		compare_stores("load_use");
	endtask

	task automatic branch_skips();
		word_t v1, v2, v3, v4;
		v1 = 32'd5;
		v2 = 32'd5;
		v3 = 32'd9;
		v4 = 32'd77;
		start_test();
		emit(addi(1, 0, 5));
		emit(addi(2, 0, 5));
		emit(addi(3, 0, 9));
		emit(beq(1, 2, 12));
		emit(sw(1, 0, 'h140));
		emit(sw(2, 0, 'h144));
		emit(beq(1, 3, 12));
		emit(sw(3, 0, 'h148));
		emit(sw(1, 0, 'h14c));
		emit(addi(4, 0, 77));
		emit(beq(4, 4, 12));
		emit(sw(4, 0, 'h150));
		emit(sw(4, 0, 'h154));
		emit(sw(4, 0, 'h158));
		emit_end();
		if (v1 != v2) begin
			expect_store(32'h140, v1);
			expect_store(32'h144, v2);
		end
		if (v1 != v3) begin
			expect_store(32'h148, v3);
			expect_store(32'h14c, v1);
		end
		expect_store(32'h158, v4);
		release_reset();
		wait_for_end();
		compare_stores("branch");
	endtask

	task automatic jal_redirect();
		word_t link1, link2;
		start_test();
		emit(addi(1, 0, 11));
		link1 = word_t'(slot * 4 + 4);
		emit(jal(5, 12));
		emit(sw(1, 0, 'h160));
		emit(sw(1, 0, 'h164));
		emit(sw(5, 0, 'h168));
		link2 = word_t'(slot * 4 + 4);
		emit(jal(6, 12));
		emit(sw(1, 0, 'h16c));
		emit(sw(1, 0, 'h170));
		emit(sw(6, 0, 'h174));
		emit(sw(1, 0, 'h178));
		emit_end();
		expect_store(32'h168, link1);
		expect_store(32'h174, link2);
		expect_store(32'h178, 32'd11);
		release_reset();
		wait_for_end();
		compare_stores("jal");
	endtask

	initial begin
		reset = 1'b0;
		arith_forwarding();
		slt_and_x0();
		load_use_stall();
		branch_skips();
		jal_redirect();
		$display("sim passed");
		$finish;
	end

endmodule

/* sources.f */
hdl/core_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/mem_writeback.sv
hdl/pipeline_core.sv
sim/core_assert.sv
sim/core_tb.sv
